//--- biq_top.f
+incdir+.
biq_pkg.sv
biq_entry.sv
biq_ctrl.sv
biq_issue_sel.sv
biq_top.sv
biq_sva.sv
biq_tb.sv

//--- biq_tb.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_tb;

    import biq_pkg::*;

    typedef struct {
        iid_t    iid;
        opcode_t opcode;
        funct7_t funct7;
        funct3_t funct3;
        xlen_t   pc;
        logic    psrc1_vld;
        preg_t   psrc1;
        logic    psrc2_vld;
        preg_t   psrc2;
        logic    pdst_vld;
        preg_t   pdst;
        logic    imm_vld;
        xlen_t   imm;
        logic    rdy1;
        logic    rdy2;
    } rec_t;

    logic        clk;
    logic        rst_clk;
    logic        global_flush;
    logic        dispatch_stall;
    logic        in_vld;
    pipe_t       in_pipe;
    iid_t        in_iid;
    opcode_t     in_opcode;
    funct7_t     in_funct7;
    funct3_t     in_funct3;
    xlen_t       in_pc;
    logic        in_psrc1_vld;
    logic        in_psrc1_ready;
    preg_t       in_psrc1;
    logic        in_psrc2_vld;
    logic        in_psrc2_ready;
    preg_t       in_psrc2;
    logic        in_pdst_vld;
    preg_t       in_pdst;
    logic        in_imm_vld;
    xlen_t       in_imm;
    wake_vld_t   wake_vld;
    wake_preg_t  wake_preg;
    logic        biq_stall;
    logic        biq_vld;
    iid_t        biq_iid;
    opcode_t     biq_opcode;
    funct7_t     biq_funct7;
    funct3_t     biq_funct3;
    xlen_t       biq_pc;
    logic        biq_psrc1_vld;
    preg_t       biq_psrc1;
    logic        biq_psrc2_vld;
    preg_t       biq_psrc2;
    logic        biq_pdst_vld;
    preg_t       biq_pdst;
    logic        biq_imm_vld;
    xlen_t       biq_imm;

    rec_t        model_q[$];    // oldest branch at index 0.
    logic [31:0] seed;
    int          stall_seen;
    int          issue_cnt;

    biq_top u_dut (.*);

    bind biq_ctrl biq_sva u_sva (
        .clk          (clk),
        .rst_clk      (rst_clk),
        .global_flush (global_flush),
        .biq_stall    (biq_stall),
        .tail_ptr     (tail_ptr),
        .cnt          (cnt),
        .create_sel   (create_sel),
        .issue_sel    (issue_sel)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rnd();
        seed = xorshift(seed);
        return seed;
    endfunction

    function logic chance(input int pct);
        return (rnd() % 100) < pct;
    endfunction

    function automatic logic tag_woken(input preg_t tag);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `BIQ_WAKE_NUM; i++)
            if (wake_vld[i] && (wake_preg[i] == tag))
                hit = 1'b1;
        return hit;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    // ========================================
    // reference model
    // ========================================
    task automatic check_outputs();
        logic exp_vld;
        exp_vld = (model_q.size() > 0) && model_q[0].rdy1 && model_q[0].rdy2;
        compare("biq_vld", biq_vld, exp_vld);
        compare("biq_stall", biq_stall, model_q.size() == 4);
        if (biq_stall === 1'b1)
            stall_seen++;
        if (biq_vld === 1'b1)
            issue_cnt++;
        if (exp_vld)
        begin
            compare("biq_iid", biq_iid, model_q[0].iid);
            compare("biq_opcode", biq_opcode, model_q[0].opcode);
            compare("biq_funct7", biq_funct7, model_q[0].funct7);
            compare("biq_funct3", biq_funct3, model_q[0].funct3);
            compare("biq_pc", biq_pc, model_q[0].pc);
            compare("biq_psrc1_vld", biq_psrc1_vld, model_q[0].psrc1_vld);
            compare("biq_psrc1", biq_psrc1, model_q[0].psrc1);
            compare("biq_psrc2_vld", biq_psrc2_vld, model_q[0].psrc2_vld);
            compare("biq_psrc2", biq_psrc2, model_q[0].psrc2);
            compare("biq_pdst_vld", biq_pdst_vld, model_q[0].pdst_vld);
            compare("biq_pdst", biq_pdst, model_q[0].pdst);
            compare("biq_imm_vld", biq_imm_vld, model_q[0].imm_vld);
            compare("biq_imm", biq_imm, model_q[0].imm);
        end
    endtask

    // applies the inputs just driven as the next rising edge would.
    task automatic update_model();
        logic exp_vld;
        logic create;
        rec_t r;
        exp_vld = (model_q.size() > 0) && model_q[0].rdy1 && model_q[0].rdy2;
        if (global_flush)
            model_q.delete();
        else
        begin
            create = in_vld && in_pipe[`BIQ_PIPE_BIT] && !dispatch_stall
                     && (model_q.size() < 4);     // full refuses even with an issue.
            if (exp_vld)
                model_q.delete(0);
            foreach (model_q[i])
            begin
                model_q[i].rdy1 = model_q[i].rdy1 | tag_woken(model_q[i].psrc1);
                model_q[i].rdy2 = model_q[i].rdy2 | tag_woken(model_q[i].psrc2);
            end
            if (create)
            begin
                r.iid       = in_iid;
                r.opcode    = in_opcode;
                r.funct7    = in_funct7;
                r.funct3    = in_funct3;
                r.pc        = in_pc;
                r.psrc1_vld = in_psrc1_vld;
                r.psrc1     = in_psrc1;
                r.psrc2_vld = in_psrc2_vld;
                r.psrc2     = in_psrc2;
                r.pdst_vld  = in_pdst_vld;
                r.pdst      = in_pdst;
                r.imm_vld   = in_imm_vld;
                r.imm       = in_imm;
                r.rdy1      = !in_psrc1_vld || in_psrc1_ready || tag_woken(in_psrc1);
                r.rdy2      = !in_psrc2_vld || in_psrc2_ready || tag_woken(in_psrc2);
                model_q.push_back(r);
            end
        end
    endtask

    // ========================================
    // stimulus
    // ========================================
    task automatic drive_inputs(input int vld_pct, input int src_pct, input int rdy_pct,
                                input int wake_pct, input int flush_pct, input bit filt);
        in_vld                 = chance(vld_pct);
        in_pipe                = pipe_t'(rnd());
        in_pipe[`BIQ_PIPE_BIT] = filt ? chance(80) : 1'b1;
        dispatch_stall         = filt ? chance(15) : 1'b0;
        global_flush           = chance(flush_pct);
        in_iid                 = iid_t'(rnd());
        in_opcode              = opcode_t'(rnd());
        in_funct7              = funct7_t'(rnd());
        in_funct3              = funct3_t'(rnd());
        in_pc                  = {rnd(), rnd()};
        in_psrc1_vld           = chance(src_pct);
        in_psrc1_ready         = chance(rdy_pct);
        in_psrc1               = preg_t'(rnd() % 8);   // small tag range so wakes hit often.
        in_psrc2_vld           = chance(src_pct);
        in_psrc2_ready         = chance(rdy_pct);
        in_psrc2               = preg_t'(rnd() % 8);
        in_pdst_vld            = chance(50);
        in_pdst                = preg_t'(rnd());
        in_imm_vld             = chance(50);
        in_imm                 = {rnd(), rnd()};
        for (int i = 0; i < `BIQ_WAKE_NUM; i++)
        begin
            wake_vld[i]  = chance(wake_pct);
            wake_preg[i] = preg_t'(rnd() % 8);
        end
    endtask

    task automatic run_cycle(input int vld_pct, input int src_pct, input int rdy_pct,
                             input int wake_pct, input int flush_pct, input bit filt);
        @(negedge clk);
        check_outputs();
        drive_inputs(vld_pct, src_pct, rdy_pct, wake_pct, flush_pct, filt);
        update_model();
    endtask

    // no dispatch, heavy wake traffic until the queue is empty.
    task automatic drain();
        int cycles;
        cycles = 0;
        while (model_q.size() > 0)
        begin
            if (cycles == 200)
            begin
                $display("timeout: the queue did not drain within 200 cycles");
                $display("Errors found");
                $fatal(1, "drain timeout");
            end
            else
            begin
                run_cycle(0, 50, 0, 100, 0, 1'b0);
                cycles++;
            end
        end
    endtask

    initial
    begin
        seed           = 32'hceb;
        stall_seen     = 0;
        issue_cnt      = 0;
        clk            = 1'b0;
        rst_clk        = 1'b0;
        global_flush   = 1'b0;
        dispatch_stall = 1'b0;
        in_vld         = 1'b0;
        in_pipe        = '0;
        in_iid         = '0;
        in_opcode      = '0;
        in_funct7      = '0;
        in_funct3      = '0;
        in_pc          = '0;
        in_psrc1_vld   = 1'b0;
        in_psrc1_ready = 1'b0;
        in_psrc1       = '0;
        in_psrc2_vld   = 1'b0;
        in_psrc2_ready = 1'b0;
        in_psrc2       = '0;
        in_pdst_vld    = 1'b0;
        in_pdst        = '0;
        in_imm_vld     = 1'b0;
        in_imm         = '0;
        wake_vld       = '0;
        wake_preg      = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_clk = 1'b1;

        repeat (400) run_cycle(60, 70, 40, 30, 2, 1'b1);   // mixed traffic with filtering.
        drain();

        // fill with waiting branches, then let them go one by one.
        stall_seen = 0;
        repeat (8) run_cycle(100, 100, 0, 0, 0, 1'b0);
        if (stall_seen == 0)
        begin
            $display("the queue never reported full after eight dispatches");
            $display("Errors found");
            $fatal(1, "no stall");
        end
        drain();

        // flush a partly filled queue, then ready branches must issue in order.
        repeat (3) run_cycle(100, 100, 0, 0, 0, 1'b0);
        run_cycle(0, 100, 0, 0, 100, 1'b0);
        repeat (20) run_cycle(100, 50, 100, 0, 0, 1'b0);
        drain();

        repeat (400) run_cycle(70, 80, 20, 20, 1, 1'b1);
        drain();
        run_cycle(0, 0, 0, 0, 0, 1'b0);

        if (issue_cnt == 0)
        begin
            $display("no branch issued during the whole run");
            $display("Errors found");
            $fatal(1, "no issue");
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- biq_sva.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_sva (
    input  logic                 clk,
    input  logic                 rst_clk,
    input  logic                 global_flush,
    input  logic                 biq_stall,
    input  biq_pkg::biq_ptr_t    tail_ptr,
    input  biq_pkg::biq_cnt_t    cnt,
    input  biq_pkg::entry_mask_t create_sel,
    input  biq_pkg::entry_mask_t issue_sel
);

    import biq_pkg::*;

    // ========================================
    // controller checks
    // ========================================
    cnt_in_range: assert property (@(posedge clk) disable iff (!rst_clk)
        cnt <= biq_cnt_t'(`BIQ_DEPTH))
        else $error("count is above the queue depth");

    // a full queue keeps its tail even when the head issues.
    no_create_full: assert property (@(posedge clk) disable iff (!rst_clk)
        (biq_stall && !global_flush) |=> $stable(tail_ptr))
        else $error("create accepted while the queue is full");

    create_onehot: assert property (@(posedge clk) disable iff (!rst_clk)
        $onehot0(create_sel))
        else $error("create select has more than one bit set");

    issue_onehot: assert property (@(posedge clk) disable iff (!rst_clk)
        $onehot0(issue_sel))
        else $error("issue select has more than one bit set");

    flush_empties: assert property (@(posedge clk) disable iff (!rst_clk)
        global_flush |=> (cnt == '0) && (issue_sel == '0))
        else $error("queue not empty after a flush");

endmodule

//--- biq_top.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_top (
    input  logic                 clk,
    input  logic                 rst_clk,
    input  logic                 global_flush,
    input  logic                 dispatch_stall,
    input  logic                 in_vld,
    input  biq_pkg::pipe_t       in_pipe,
    input  biq_pkg::iid_t        in_iid,
    input  biq_pkg::opcode_t     in_opcode,
    input  biq_pkg::funct7_t     in_funct7,
    input  biq_pkg::funct3_t     in_funct3,
    input  biq_pkg::xlen_t       in_pc,
    input  logic                 in_psrc1_vld,
    input  logic                 in_psrc1_ready,
    input  biq_pkg::preg_t       in_psrc1,
    input  logic                 in_psrc2_vld,
    input  logic                 in_psrc2_ready,
    input  biq_pkg::preg_t       in_psrc2,
    input  logic                 in_pdst_vld,
    input  biq_pkg::preg_t       in_pdst,
    input  logic                 in_imm_vld,
    input  biq_pkg::xlen_t       in_imm,
    input  biq_pkg::wake_vld_t   wake_vld,
    input  biq_pkg::wake_preg_t  wake_preg,
    output logic                 biq_stall,
    output logic                 biq_vld,
    output biq_pkg::iid_t        biq_iid,
    output biq_pkg::opcode_t     biq_opcode,
    output biq_pkg::funct7_t     biq_funct7,
    output biq_pkg::funct3_t     biq_funct3,
    output biq_pkg::xlen_t       biq_pc,
    output logic                 biq_psrc1_vld,
    output biq_pkg::preg_t       biq_psrc1,
    output logic                 biq_psrc2_vld,
    output biq_pkg::preg_t       biq_psrc2,
    output logic                 biq_pdst_vld,
    output biq_pkg::preg_t       biq_pdst,
    output logic                 biq_imm_vld,
    output biq_pkg::xlen_t       biq_imm
);

    import biq_pkg::*;

    entry_mask_t                  create_sel;
    entry_mask_t                  issue_sel;
    entry_mask_t                  entry_ready;
    entry_mask_t                  entry_psrc1_vld;
    entry_mask_t                  entry_psrc2_vld;
    entry_mask_t                  entry_pdst_vld;
    entry_mask_t                  entry_imm_vld;
    iid_t    [`BIQ_DEPTH-1:0]     entry_iid;
    opcode_t [`BIQ_DEPTH-1:0]     entry_opcode;
    funct7_t [`BIQ_DEPTH-1:0]     entry_funct7;
    funct3_t [`BIQ_DEPTH-1:0]     entry_funct3;
    xlen_t   [`BIQ_DEPTH-1:0]     entry_pc;
    preg_t   [`BIQ_DEPTH-1:0]     entry_psrc1;
    preg_t   [`BIQ_DEPTH-1:0]     entry_psrc2;
    preg_t   [`BIQ_DEPTH-1:0]     entry_pdst;
    xlen_t   [`BIQ_DEPTH-1:0]     entry_imm;

    // ========================================
    // control
    // ========================================
    biq_ctrl u_ctrl (
        .clk            (clk),
        .rst_clk        (rst_clk),
        .global_flush   (global_flush),
        .in_vld         (in_vld),
        .in_pipe        (in_pipe),
        .dispatch_stall (dispatch_stall),
        .entry_ready    (entry_ready),
        .create_sel     (create_sel),
        .issue_sel      (issue_sel),
        .biq_vld        (biq_vld),
        .biq_stall      (biq_stall)
    );

    // ========================================
    // entries
    // ========================================
    // dispatch fields and the wake bus reach every entry by name.
    biq_entry u_entry0 (
        .create    (create_sel[0]),
        .issue     (issue_sel[0]),
        .vld       (),                    // occupancy is tracked by the controller count.
        .ready     (entry_ready[0]),
        .iid       (entry_iid[0]),
        .opcode    (entry_opcode[0]),
        .funct7    (entry_funct7[0]),
        .funct3    (entry_funct3[0]),
        .pc        (entry_pc[0]),
        .psrc1_vld (entry_psrc1_vld[0]),
        .psrc1     (entry_psrc1[0]),
        .psrc2_vld (entry_psrc2_vld[0]),
        .psrc2     (entry_psrc2[0]),
        .pdst_vld  (entry_pdst_vld[0]),
        .pdst      (entry_pdst[0]),
        .imm_vld   (entry_imm_vld[0]),
        .imm       (entry_imm[0]),
        .*
    );

    biq_entry u_entry1 (
        .create    (create_sel[1]),
        .issue     (issue_sel[1]),
        .vld       (),
        .ready     (entry_ready[1]),
        .iid       (entry_iid[1]),
        .opcode    (entry_opcode[1]),
        .funct7    (entry_funct7[1]),
        .funct3    (entry_funct3[1]),
        .pc        (entry_pc[1]),
        .psrc1_vld (entry_psrc1_vld[1]),
        .psrc1     (entry_psrc1[1]),
        .psrc2_vld (entry_psrc2_vld[1]),
        .psrc2     (entry_psrc2[1]),
        .pdst_vld  (entry_pdst_vld[1]),
        .pdst      (entry_pdst[1]),
        .imm_vld   (entry_imm_vld[1]),
        .imm       (entry_imm[1]),
        .*
    );

    biq_entry u_entry2 (
        .create    (create_sel[2]),
        .issue     (issue_sel[2]),
        .vld       (),
        .ready     (entry_ready[2]),
        .iid       (entry_iid[2]),
        .opcode    (entry_opcode[2]),
        .funct7    (entry_funct7[2]),
        .funct3    (entry_funct3[2]),
        .pc        (entry_pc[2]),
        .psrc1_vld (entry_psrc1_vld[2]),
        .psrc1     (entry_psrc1[2]),
        .psrc2_vld (entry_psrc2_vld[2]),
        .psrc2     (entry_psrc2[2]),
        .pdst_vld  (entry_pdst_vld[2]),
        .pdst      (entry_pdst[2]),
        .imm_vld   (entry_imm_vld[2]),
        .imm       (entry_imm[2]),
        .*
    );

    biq_entry u_entry3 (
        .create    (create_sel[3]),
        .issue     (issue_sel[3]),
        .vld       (),
        .ready     (entry_ready[3]),
        .iid       (entry_iid[3]),
        .opcode    (entry_opcode[3]),
        .funct7    (entry_funct7[3]),
        .funct3    (entry_funct3[3]),
        .pc        (entry_pc[3]),
        .psrc1_vld (entry_psrc1_vld[3]),
        .psrc1     (entry_psrc1[3]),
        .psrc2_vld (entry_psrc2_vld[3]),
        .psrc2     (entry_psrc2[3]),
        .pdst_vld  (entry_pdst_vld[3]),
        .pdst      (entry_pdst[3]),
        .imm_vld   (entry_imm_vld[3]),
        .imm       (entry_imm[3]),
        .*
    );

    // head entry fields onto the biq_* outputs.
    biq_issue_sel u_sel (
        .*
    );

endmodule

//--- biq_issue_sel.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_issue_sel (
    input  biq_pkg::entry_mask_t                  issue_sel,
    input  biq_pkg::iid_t    [`BIQ_DEPTH-1:0]     entry_iid,
    input  biq_pkg::opcode_t [`BIQ_DEPTH-1:0]     entry_opcode,
    input  biq_pkg::funct7_t [`BIQ_DEPTH-1:0]     entry_funct7,
    input  biq_pkg::funct3_t [`BIQ_DEPTH-1:0]     entry_funct3,
    input  biq_pkg::xlen_t   [`BIQ_DEPTH-1:0]     entry_pc,
    input  biq_pkg::entry_mask_t                  entry_psrc1_vld,
    input  biq_pkg::preg_t   [`BIQ_DEPTH-1:0]     entry_psrc1,
    input  biq_pkg::entry_mask_t                  entry_psrc2_vld,
    input  biq_pkg::preg_t   [`BIQ_DEPTH-1:0]     entry_psrc2,
    input  biq_pkg::entry_mask_t                  entry_pdst_vld,
    input  biq_pkg::preg_t   [`BIQ_DEPTH-1:0]     entry_pdst,
    input  biq_pkg::entry_mask_t                  entry_imm_vld,
    input  biq_pkg::xlen_t   [`BIQ_DEPTH-1:0]     entry_imm,
    output biq_pkg::iid_t                         biq_iid,
    output biq_pkg::opcode_t                      biq_opcode,
    output biq_pkg::funct7_t                      biq_funct7,
    output biq_pkg::funct3_t                      biq_funct3,
    output biq_pkg::xlen_t                        biq_pc,
    output logic                                  biq_psrc1_vld,
    output biq_pkg::preg_t                        biq_psrc1,
    output logic                                  biq_psrc2_vld,
    output biq_pkg::preg_t                        biq_psrc2,
    output logic                                  biq_pdst_vld,
    output biq_pkg::preg_t                        biq_pdst,
    output logic                                  biq_imm_vld,
    output biq_pkg::xlen_t                        biq_imm
);

    import biq_pkg::*;

    // one-hot select, so all outputs are zero when nothing issues.
    always_comb
    begin
        biq_iid    = '0;
        biq_opcode = '0;
        biq_funct7 = '0;
        biq_funct3 = '0;
        biq_pc     = '0;
        biq_psrc1  = '0;
        biq_psrc2  = '0;
        biq_pdst   = '0;
        biq_imm    = '0;
        for (int i = 0; i < `BIQ_DEPTH; i++)
        begin
            biq_iid    = biq_iid    | (entry_iid[i]    & {$bits(iid_t){issue_sel[i]}});
            biq_opcode = biq_opcode | (entry_opcode[i] & {$bits(opcode_t){issue_sel[i]}});
            biq_funct7 = biq_funct7 | (entry_funct7[i] & {$bits(funct7_t){issue_sel[i]}});
            biq_funct3 = biq_funct3 | (entry_funct3[i] & {$bits(funct3_t){issue_sel[i]}});
            biq_pc     = biq_pc     | (entry_pc[i]     & {$bits(xlen_t){issue_sel[i]}});
            biq_psrc1  = biq_psrc1  | (entry_psrc1[i]  & {$bits(preg_t){issue_sel[i]}});
            biq_psrc2  = biq_psrc2  | (entry_psrc2[i]  & {$bits(preg_t){issue_sel[i]}});
            biq_pdst   = biq_pdst   | (entry_pdst[i]   & {$bits(preg_t){issue_sel[i]}});
            biq_imm    = biq_imm    | (entry_imm[i]    & {$bits(xlen_t){issue_sel[i]}});
        end
    end

    assign biq_psrc1_vld = |(entry_psrc1_vld & issue_sel);
    assign biq_psrc2_vld = |(entry_psrc2_vld & issue_sel);
    assign biq_pdst_vld  = |(entry_pdst_vld & issue_sel);
    assign biq_imm_vld   = |(entry_imm_vld & issue_sel);

endmodule

//--- biq_ctrl.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_ctrl (
    input  logic                 clk,
    input  logic                 rst_clk,
    input  logic                 global_flush,
    input  logic                 in_vld,
    input  biq_pkg::pipe_t       in_pipe,
    input  logic                 dispatch_stall,
    input  biq_pkg::entry_mask_t entry_ready,
    output biq_pkg::entry_mask_t create_sel,
    output biq_pkg::entry_mask_t issue_sel,
    output logic                 biq_vld,
    output logic                 biq_stall
);

    import biq_pkg::*;

    biq_ptr_t head_ptr;
    biq_ptr_t tail_ptr;
    biq_cnt_t cnt;
    logic     create_vld;

    // ========================================
    // create and issue selects
    // ========================================
    // a full queue refuses a create even if the head issues this cycle.
    assign create_vld = in_vld & in_pipe[`BIQ_PIPE_BIT] & ~dispatch_stall & ~biq_stall;

    assign create_sel = {`BIQ_DEPTH{create_vld}} & (entry_mask_t'(1) << tail_ptr);
    assign issue_sel  = entry_ready & (entry_mask_t'(1) << head_ptr);   // only the head may go.

    assign biq_vld   = |issue_sel;
    assign biq_stall = (cnt == biq_cnt_t'(`BIQ_DEPTH));

    // ========================================
    // pointers and count
    // ========================================
    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else if (global_flush)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else
        begin
            if (biq_vld)
                head_ptr <= head_ptr + 1'b1;     // wraps at the depth.
            if (create_vld)
                tail_ptr <= tail_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
            cnt <= '0;
        else if (global_flush)
            cnt <= '0;
        else
        begin
            case ({create_vld, biq_vld})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;             // both or neither.
            endcase
        end
    end

endmodule

//--- biq_entry.sv
`timescale 1ns/100ps
`include "biq_defines.svh"

module biq_entry (
    input  logic                 clk,
    input  logic                 rst_clk,
    input  logic                 global_flush,
    input  logic                 create,
    input  logic                 issue,
    input  biq_pkg::iid_t        in_iid,
    input  biq_pkg::opcode_t     in_opcode,
    input  biq_pkg::funct7_t     in_funct7,
    input  biq_pkg::funct3_t     in_funct3,
    input  biq_pkg::xlen_t       in_pc,
    input  logic                 in_psrc1_vld,
    input  logic                 in_psrc1_ready,
    input  biq_pkg::preg_t       in_psrc1,
    input  logic                 in_psrc2_vld,
    input  logic                 in_psrc2_ready,
    input  biq_pkg::preg_t       in_psrc2,
    input  logic                 in_pdst_vld,
    input  biq_pkg::preg_t       in_pdst,
    input  logic                 in_imm_vld,
    input  biq_pkg::xlen_t       in_imm,
    input  biq_pkg::wake_vld_t   wake_vld,
    input  biq_pkg::wake_preg_t  wake_preg,
    output logic                 vld,
    output logic                 ready,
    output biq_pkg::iid_t        iid,
    output biq_pkg::opcode_t     opcode,
    output biq_pkg::funct7_t     funct7,
    output biq_pkg::funct3_t     funct3,
    output biq_pkg::xlen_t       pc,
    output logic                 psrc1_vld,
    output biq_pkg::preg_t       psrc1,
    output logic                 psrc2_vld,
    output biq_pkg::preg_t       psrc2,
    output logic                 pdst_vld,
    output biq_pkg::preg_t       pdst,
    output logic                 imm_vld,
    output biq_pkg::xlen_t       imm
);

    logic psrc1_rdy;
    logic psrc2_rdy;
    logic wake_hit1;
    logic wake_hit2;

    // ========================================
    // wake tag compare
    // ========================================
    // in the create cycle the incoming tags are compared.
    always_comb
    begin
        wake_hit1 = 1'b0;
        wake_hit2 = 1'b0;
        for (int i = 0; i < `BIQ_WAKE_NUM; i++)
        begin
            if (wake_vld[i] && (wake_preg[i] == (create ? in_psrc1 : psrc1)))
                wake_hit1 = 1'b1;
            if (wake_vld[i] && (wake_preg[i] == (create ? in_psrc2 : psrc2)))
                wake_hit2 = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            vld       <= 1'b0;
            psrc1_rdy <= 1'b0;
            psrc2_rdy <= 1'b0;
        end
        else if (global_flush)
        begin
            vld       <= 1'b0;
            psrc1_rdy <= 1'b0;
            psrc2_rdy <= 1'b0;
        end
        else if (create)
        begin
            vld       <= 1'b1;
            psrc1_rdy <= ~in_psrc1_vld | in_psrc1_ready | wake_hit1;   // unused source is ready.
            psrc2_rdy <= ~in_psrc2_vld | in_psrc2_ready | wake_hit2;
        end
        else if (issue)
            vld <= 1'b0;
        else
        begin
            psrc1_rdy <= psrc1_rdy | wake_hit1;
            psrc2_rdy <= psrc2_rdy | wake_hit2;
        end
    end

    // ========================================
    // payload
    // ========================================
    always_ff @(posedge clk)
    begin
        if (create)
        begin
            iid       <= in_iid;
            opcode    <= in_opcode;
            funct7    <= in_funct7;
            funct3    <= in_funct3;
            pc        <= in_pc;
            psrc1_vld <= in_psrc1_vld;
            psrc1     <= in_psrc1;
            psrc2_vld <= in_psrc2_vld;
            psrc2     <= in_psrc2;
            pdst_vld  <= in_pdst_vld;
            pdst      <= in_pdst;
            imm_vld   <= in_imm_vld;
            imm       <= in_imm;
        end
    end

    assign ready = vld & psrc1_rdy & psrc2_rdy;

endmodule

//--- biq_pkg.sv
`include "biq_defines.svh"

package biq_pkg;

    // instruction fields.
    typedef logic [`BIQ_IID_W-1:0]    iid_t;
    typedef logic [`BIQ_PREG_W-1:0]   preg_t;
    typedef logic [`BIQ_OPC_W-1:0]    opcode_t;
    typedef logic [`BIQ_F7_W-1:0]     funct7_t;
    typedef logic [`BIQ_F3_W-1:0]     funct3_t;
    typedef logic [`BIQ_XLEN-1:0]     xlen_t;
    typedef logic [`BIQ_PIPE_W-1:0]   pipe_t;

    // queue bookkeeping.
    typedef logic [`BIQ_PTR_W-1:0]    biq_ptr_t;
    typedef logic [`BIQ_CNT_W-1:0]    biq_cnt_t;
    typedef logic [`BIQ_DEPTH-1:0]    entry_mask_t;

    // ========================================
    // wake bus
    // ========================================
    typedef logic [`BIQ_WAKE_NUM-1:0] wake_vld_t;
    typedef preg_t [`BIQ_WAKE_NUM-1:0] wake_preg_t;   // one tag per wake source.

endpackage

//--- biq_defines.svh
`ifndef BIQ_DEFINES_SVH
`define BIQ_DEFINES_SVH

// ========================================
// queue geometry
// ========================================
`define BIQ_DEPTH     4
`define BIQ_PTR_W     2
`define BIQ_CNT_W     3

// ========================================
// instruction fields
// ========================================
`define BIQ_IID_W     5
`define BIQ_PREG_W    6
`define BIQ_XLEN      64
`define BIQ_OPC_W     7
`define BIQ_F7_W      7
`define BIQ_F3_W      3
`define BIQ_PIPE_W    5
`define BIQ_PIPE_BIT  2      // branch pipe in the one-hot pipe select.
`define BIQ_WAKE_NUM  4      // alu issue fwd, alu result, mul result, lsu result.

`endif
